/* hw/remainder_pkg.sv */
// Fixed at 8-bit two's-complement operands; all modules size themselves from word_width here
`default_nettype none

package remainder_pkg;

    // Operand and result width
    localparam int word_width = 8;

    // One extra bit so the most negative dividend can still be driven to zero
    // (e.g. -128 rem 1 needs an increment of +128)
    localparam int word_width_long = word_width + 1;

    // Step counter runs from word_width_long - 1 down to zero
    localparam int steps_width = $clog2(word_width_long);
    localparam logic [steps_width-1:0] steps_initial = steps_width'(word_width_long - 1);

    // Control sequence load -> calc -> done, encoding is arbitrary
    typedef enum logic [1:0] {
        state_load = 2'b00,
        state_calc = 2'b10,
        state_done = 2'b11
    } state_t;

    // Operation selector for the remainder step
    localparam logic add_sub_add = 1'b0;
    localparam logic add_sub_sub = 1'b1;

    // Two's-complement sign bit values
    localparam logic sign_positive = 1'b0;
    localparam logic sign_negative = 1'b1;

endpackage

`default_nettype wire

/* hw/divide_control.sv */
// One operation at a time; output_valid rises nine edges after the accepting edge (ten cycles with the accept cycle)
`default_nettype none

module divide_control (
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic input_valid,
    input  wire logic output_ready,
    output logic      input_ready,
    output logic      output_valid,
    output logic      load,
    output logic      step
);

    remainder_pkg::state_t                 state;
    remainder_pkg::state_t                 state_next;
    logic [remainder_pkg::steps_width-1:0] step_count;
    logic                                  last_step;
    logic                                  deliver;

    // Handshake outputs come straight from the state
    assign input_ready  = (state == remainder_pkg::state_load);
    assign output_valid = (state == remainder_pkg::state_done);

    // Input transfer loads both data paths
    assign load = input_valid && input_ready;

    // Output transfer frees the unit for the next operand pair
    assign deliver = output_valid && output_ready;

    // Every calc cycle is one step, nothing stalls inside the iteration
    assign step = (state == remainder_pkg::state_calc);

    // Step at count zero uses the unshifted divisor, the smallest increment
    assign last_step = step && (step_count == '0);

    always_comb begin
        state_next = state;
        case (state)
            remainder_pkg::state_load: begin
                if (load) begin
                    state_next = remainder_pkg::state_calc;
                end
            end
            remainder_pkg::state_calc: begin
                if (last_step) begin
                    state_next = remainder_pkg::state_done;
                end
            end
            remainder_pkg::state_done: begin
                // Hold the result until the consumer takes it
                if (deliver) begin
                    state_next = remainder_pkg::state_load;
                end
            end
            default: begin
                state_next = remainder_pkg::state_load;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= remainder_pkg::state_load;
        end else begin
            state <= state_next;
        end
    end

    // Counts down word_width_long steps, restarted by each load
    always_ff @(posedge clock) begin
        if (reset) begin
            step_count <= remainder_pkg::steps_initial;
        end else if (load) begin
            step_count <= remainder_pkg::steps_initial;
        end else if (step) begin
            // Wraps after the last step, harmless since load restarts it
            step_count <= step_count - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/divisor_shifter.sv */
// Divisor is sign-extended to word_width_long; outputs are meaningful only after a load
`default_nettype none

module divisor_shifter (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  load,
    input  wire logic                                  step,
    input  wire logic [remainder_pkg::word_width-1:0]  divisor,
    output logic                                       divisor_sign,
    output logic [remainder_pkg::word_width_long-1:0]  increment,
    output logic                                       increment_valid,
    output logic                                       divide_by_zero
);

    logic [remainder_pkg::word_width_long-1:0] divisor_long;
    logic [remainder_pkg::word_width_long-1:0] divisor_shift;
    logic                                      divisor_all_sign;

    // Sign extension by one bit
    assign divisor_long = {divisor[remainder_pkg::word_width-1], divisor};

    // {divisor_shift, increment} acts as one double-width word holding the divisor
    // shifted left by word_width; each step is an arithmetic shift right of that word,
    // so the increment walks from divisor << word_width down to the divisor itself
    always_ff @(posedge clock) begin
        if (load) begin
            // First shift is folded into the load
            divisor_shift <= {divisor_long[remainder_pkg::word_width_long-1],
                              divisor_long[remainder_pkg::word_width_long-1:1]};
            increment     <= {divisor_long[0], {remainder_pkg::word_width{1'b0}}};
            divisor_sign  <= divisor_long[remainder_pkg::word_width_long-1];
        end else if (step) begin
            // Sign bit is replicated, low bit moves into the top of the increment
            divisor_shift <= {divisor_shift[remainder_pkg::word_width_long-1],
                              divisor_shift[remainder_pkg::word_width_long-1:1]};
            increment     <= {divisor_shift[0],
                              increment[remainder_pkg::word_width_long-1:1]};
        end
    end

    // Flag is held with the result until the next load
    always_ff @(posedge clock) begin
        if (reset) begin
            divide_by_zero <= 1'b0;
        end else if (load) begin
            divide_by_zero <= (divisor == '0);
        end
    end

    // Upper half carries no significant bits any more
    assign divisor_all_sign = (divisor_sign == remainder_pkg::sign_positive) ?
                              (divisor_shift == '0) : (divisor_shift == '1);

    // Increment is a correct multiple only when nothing is left above it
    // and its own sign already matches the divisor sign
    // Caller chooses add_sub_add or add_sub_sub from divisor_sign, not here
    assign increment_valid = divisor_all_sign &&
                             (increment[remainder_pkg::word_width_long-1] == divisor_sign);

endmodule

`default_nettype wire

/* hw/remainder_accumulator.sv */
// Truncated signed remainder; the result keeps the dividend sign and is read after the last step
`default_nettype none

module remainder_accumulator (
    input  wire logic                                  clock,
    input  wire logic                                  reset,
    input  wire logic                                  load,
    input  wire logic                                  step,
    input  wire logic [remainder_pkg::word_width-1:0]  dividend,
    input  wire logic                                  divisor_sign,
    input  wire logic [remainder_pkg::word_width_long-1:0] increment,
    input  wire logic                                  increment_valid,
    output logic [remainder_pkg::word_width-1:0]       remainder
);

    logic [remainder_pkg::word_width_long-1:0] remainder_long;
    logic                                      dividend_sign;
    logic                                      add_sub;
    logic [remainder_pkg::word_width_long:0]   candidate_wide;
    logic [remainder_pkg::word_width_long-1:0] candidate;
    logic                                      overflow;
    logic                                      keeps_sign;
    logic                                      step_accept;

    // Same signs move toward zero by subtracting, opposite signs by adding
    assign add_sub = (divisor_sign == dividend_sign) ?
                     remainder_pkg::add_sub_sub : remainder_pkg::add_sub_add;

    // One guard bit on top to catch signed overflow of the long word
    always_comb begin
        if (add_sub == remainder_pkg::add_sub_sub) begin
            candidate_wide = {remainder_long[remainder_pkg::word_width_long-1], remainder_long}
                           - {increment[remainder_pkg::word_width_long-1], increment};
        end else begin
            candidate_wide = {remainder_long[remainder_pkg::word_width_long-1], remainder_long}
                           + {increment[remainder_pkg::word_width_long-1], increment};
        end
    end

    assign candidate = candidate_wide[remainder_pkg::word_width_long-1:0];

    // Guard bit differs from the sign bit on overflow
    assign overflow = candidate_wide[remainder_pkg::word_width_long] ^
                      candidate_wide[remainder_pkg::word_width_long-1];

    // Candidate is still on the dividend side of zero
    assign keeps_sign = (dividend_sign == remainder_pkg::sign_negative) ?
                        candidate[remainder_pkg::word_width_long-1] :
                        !candidate[remainder_pkg::word_width_long-1];

    // Zero is accepted explicitly, a negative dividend can reach it too
    assign step_accept = increment_valid &&
                         ((keeps_sign && !overflow) || (candidate == '0));

    always_ff @(posedge clock) begin
        if (reset) begin
            // Zero remainder with a positive sign until the first load
            remainder_long <= '0;
            dividend_sign  <= remainder_pkg::sign_positive;
        end else if (load) begin
            remainder_long <= {dividend[remainder_pkg::word_width-1], dividend};
            dividend_sign  <= dividend[remainder_pkg::word_width-1];
        end else if (step && step_accept) begin
            remainder_long <= candidate;
        end
    end

    // Magnitude is below the divisor's, so the extra bit is only a sign copy here
    assign remainder = remainder_long[remainder_pkg::word_width-1:0];

endmodule

`default_nettype wire

/* hw/remainder_top.sv */
// Single-issue remainder unit; a zero divisor returns the dividend with divide_by_zero set
`default_nettype none

module remainder_top (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 input_valid,
    input  wire logic [remainder_pkg::word_width-1:0] dividend,
    input  wire logic [remainder_pkg::word_width-1:0] divisor,
    input  wire logic                                 output_ready,
    output logic                                      input_ready,
    output logic                                      output_valid,
    output logic [remainder_pkg::word_width-1:0]      remainder,
    output logic                                      divide_by_zero
);

    // Strobes from the controller to both data paths
    logic load;
    logic step;

    // Divisor path results consumed by the remainder path
    logic                                      divisor_sign;
    logic [remainder_pkg::word_width_long-1:0] increment;
    logic                                      increment_valid;

    divide_control divide_control_inst (
        .clock        (clock),
        .reset        (reset),
        .input_valid  (input_valid),
        .output_ready (output_ready),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .load         (load),
        .step         (step)
    );

    divisor_shifter divisor_shifter_inst (
        .clock           (clock),
        .reset           (reset),
        .load            (load),
        .step            (step),
        .divisor         (divisor),
        .divisor_sign    (divisor_sign),
        .increment       (increment),
        .increment_valid (increment_valid),
        .divide_by_zero  (divide_by_zero)
    );

    // Step decision is combinational across the two data paths
    remainder_accumulator remainder_accumulator_inst (
        .clock           (clock),
        .reset           (reset),
        .load            (load),
        .step            (step),
        .dividend        (dividend),
        .divisor_sign    (divisor_sign),
        .increment       (increment),
        .increment_valid (increment_valid),
        .remainder       (remainder)
    );

endmodule

`default_nettype wire

/* testbench/remainder_sva.sv */
// Bound onto divide_control; handshake checks hold only while reset is low, except the reset check
`default_nettype none

module remainder_sva (
    input wire logic clock,
    input wire logic reset,
    input wire logic input_ready,
    input wire logic output_valid,
    input wire logic output_ready,
    input wire logic step
);
    timeunit 1ns;
    timeprecision 1ps;

    // Running total of assertion failures
    int failure_count = 0;

    // Reset leaves the controller idle and ready for operands
    reset_idle: assert property (@(posedge clock)
        reset |=> (input_ready && !output_valid && !step))
        else begin
            $error("Controller was not idle after reset");
            failure_count++;
        end

    // Ready and valid decode different states
    ready_valid_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(input_ready && output_valid))
        else begin
            $error("input_ready and output_valid were high together");
            failure_count++;
        end

    // A stalled result stays offered until the consumer takes it
    result_held: assert property (@(posedge clock) disable iff (reset)
        (output_valid && !output_ready) |=> output_valid)
        else begin
            $error("output_valid dropped before the result was taken");
            failure_count++;
        end

endmodule

`default_nettype wire

/* testbench/remainder_monitor.sv */
// Samples DUT ports on the rising edge and assumes stimulus only moves on the falling edge
`default_nettype none

module remainder_monitor (
    input wire logic                                 clock,
    input wire logic                                 reset,
    input wire logic                                 input_valid,
    input wire logic                                 input_ready,
    input wire logic [remainder_pkg::word_width-1:0] dividend,
    input wire logic [remainder_pkg::word_width-1:0] divisor,
    input wire logic                                 output_valid,
    input wire logic                                 output_ready,
    input wire logic [remainder_pkg::word_width-1:0] remainder,
    input wire logic                                 divide_by_zero
);
    timeunit 1ns;
    timeprecision 1ps;

    int error_count = 0;
    int check_count = 0;
    int accept_count = 0;
    int result_count = 0;

    // Expected results in accept order
    logic [remainder_pkg::word_width-1:0] expected_q [$];
    logic                                 flag_q [$];
    int                                   op_q [$];

    logic                                 busy = 1'b0;
    logic                                 valid_seen = 1'b0;
    logic                                 holding = 1'b0;
    int                                   latency = 0;
    int                                   current_op = 0;
    logic [remainder_pkg::word_width-1:0] held_remainder;
    logic                                 held_flag;

    // Truncated division, result takes the dividend sign
    function automatic logic [7:0] model_remainder(input logic [7:0] a, input logic [7:0] b);
        int sa;
        int sb;
        int r;
        sa = int'($signed(a));
        sb = int'($signed(b));
        if (sb == 0) begin
            return a;
        end
        r = (sa < 0 ? -sa : sa) % (sb < 0 ? -sb : sb);
        return 8'(sa < 0 ? -r : r);
    endfunction

    task automatic compare_value(input string name, input int op, input int expected,
                                 input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("ERROR op_%0d %s expected %0d actual %0d", op, name, expected, actual);
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            busy = 1'b0;
            valid_seen = 1'b0;
            holding = 1'b0;
        end else begin
            if (busy) begin
                latency++;
                if (input_ready) begin
                    error_count++;
                    $display("input_ready was high while op_%0d was in flight", current_op);
                end
            end
            if (output_valid && busy && !valid_seen) begin
                valid_seen = 1'b1;
                compare_value("latency", current_op, remainder_pkg::word_width_long + 1, latency);
            end
            // Stalled result must not move
            if (output_valid && holding) begin
                compare_value("held_remainder", current_op, int'(held_remainder), int'(remainder));
                compare_value("held_flag", current_op, int'(held_flag), int'(divide_by_zero));
            end
            if (output_valid && output_ready) begin
                if (op_q.size() == 0) begin
                    error_count++;
                    $display("An output transfer happened with no operation pending");
                end else begin
                    compare_value("remainder", op_q[0], int'($signed(expected_q[0])),
                                  int'($signed(remainder)));
                    compare_value("divide_by_zero", op_q[0], int'(flag_q[0]),
                                  int'(divide_by_zero));
                    void'(op_q.pop_front());
                    void'(expected_q.pop_front());
                    void'(flag_q.pop_front());
                    result_count++;
                end
                busy = 1'b0;
                valid_seen = 1'b0;
                holding = 1'b0;
            end else if (output_valid) begin
                holding = 1'b1;
                held_remainder = remainder;
                held_flag = divide_by_zero;
            end
            if (input_valid && input_ready) begin
                expected_q.push_back(model_remainder(dividend, divisor));
                flag_q.push_back(divisor == '0);
                op_q.push_back(accept_count);
                current_op = accept_count;
                accept_count++;
                busy = 1'b1;
                latency = 0;
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/remainder_tb.sv */
// Runs 400 seeded random operations with forced corner cases; stimulus changes on the falling edge
`default_nettype none

module remainder_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int op_count = 400;
    localparam int wait_limit = 200;

    logic                                 clock = 1'b0;
    logic                                 reset;
    logic                                 input_valid;
    logic [remainder_pkg::word_width-1:0] dividend;
    logic [remainder_pkg::word_width-1:0] divisor;
    logic                                 output_ready;
    logic                                 input_ready;
    logic                                 output_valid;
    logic [remainder_pkg::word_width-1:0] remainder;
    logic                                 divide_by_zero;

    // Operand pairs and idle gaps, all drawn before reset ends
    logic [remainder_pkg::word_width-1:0] dividend_list [op_count];
    logic [remainder_pkg::word_width-1:0] divisor_list [op_count];
    int                                   gap_list [op_count];
    int                                   sent_count = 0;
    int                                   tb_errors = 0;
    logic                                 timed_out = 1'b0;

    remainder_top remainder_top_inst (
        .clock          (clock),
        .reset          (reset),
        .input_valid    (input_valid),
        .dividend       (dividend),
        .divisor        (divisor),
        .output_ready   (output_ready),
        .input_ready    (input_ready),
        .output_valid   (output_valid),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    remainder_monitor monitor_inst (
        .clock          (clock),
        .reset          (reset),
        .input_valid    (input_valid),
        .input_ready    (input_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .output_valid   (output_valid),
        .output_ready   (output_ready),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    bind divide_control remainder_sva remainder_sva_inst (
        .clock        (clock),
        .reset        (reset),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .step         (step)
    );

    always #10 clock = ~clock;

    // Random consumer stalls, ready about three cycles in four
    initial begin
        output_ready = 1'b0;
        forever begin
            @(negedge clock);
            output_ready = (($urandom() % 4) != 0);
        end
    end

    task automatic build_stimulus();
        int kind;
        for (int op = 0; op < op_count; op++) begin
            kind = int'($urandom() % 8);
            dividend_list[op] = 8'($urandom());
            divisor_list[op] = 8'($urandom());
            gap_list[op] = int'($urandom() % 3);
            case (kind)
                0: divisor_list[op] = 8'h00;
                1: begin
                    // Most negative dividend against plus or minus one
                    dividend_list[op] = 8'h80;
                    divisor_list[op] = ($urandom() % 2 == 0) ? 8'hff : 8'h01;
                end
                2: divisor_list[op] = 8'hff;
                3: divisor_list[op] = ($urandom() % 2 == 0) ? dividend_list[op] :
                                      ~dividend_list[op] + 8'd1;
                default: ;
            endcase
        end
    endtask

    // Holds the operands until the edge that takes them
    task automatic send_operation(input logic [7:0] a, input logic [7:0] b);
        int wait_count;
        wait_count = 0;
        input_valid = 1'b1;
        dividend = a;
        divisor = b;
        while (!input_ready && wait_count < wait_limit) begin
            @(negedge clock);
            wait_count++;
        end
        if (!input_ready) begin
            $display("Timeout: input_ready stayed low for operation %0d", sent_count);
            tb_errors++;
            timed_out = 1'b1;
        end else begin
            // input_ready only moves on a rising edge, so the transfer lands there
            @(negedge clock);
            sent_count++;
        end
        input_valid = 1'b0;
    endtask

    task automatic wait_for_results();
        int wait_count;
        wait_count = 0;
        while (monitor_inst.result_count < sent_count && wait_count < wait_limit) begin
            @(negedge clock);
            wait_count++;
        end
        if (monitor_inst.result_count < sent_count) begin
            $display("Timeout: %0d results never came out",
                     sent_count - monitor_inst.result_count);
            tb_errors++;
        end
    endtask

    initial begin
        int total_errors;
        void'($urandom(32'hfabd_7509));
        reset = 1'b1;
        input_valid = 1'b0;
        dividend = '0;
        divisor = '0;
        build_stimulus();
        repeat (8) @(negedge clock);
        reset = 1'b0;
        for (int op = 0; op < op_count && !timed_out; op++) begin
            repeat (gap_list[op]) @(negedge clock);
            send_operation(dividend_list[op], divisor_list[op]);
        end
        wait_for_results();
        if (monitor_inst.result_count != sent_count) begin
            $display("Result count %0d does not match %0d sent operations",
                     monitor_inst.result_count, sent_count);
            tb_errors++;
        end
        total_errors = tb_errors + monitor_inst.error_count +
                       remainder_top_inst.divide_control_inst.remainder_sva_inst.failure_count;
        $display("operations=%0d results=%0d checks=%0d errors=%0d", sent_count,
                 monitor_inst.result_count, monitor_inst.check_count, total_errors);
        if (total_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
hw/remainder_pkg.sv
hw/divide_control.sv
hw/divisor_shifter.sv
hw/remainder_accumulator.sv
hw/remainder_top.sv
testbench/remainder_sva.sv
testbench/remainder_monitor.sv
testbench/remainder_tb.sv

/* Makefile */
SOURCES := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/Vremainder_tb: sim.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module remainder_tb -f sim.f

run: obj_dir/Vremainder_tb
	./obj_dir/Vremainder_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
